// ==== butterfly/butterfly_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module butterfly_engine import butterfly_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    operand_if.receiver                    link,
    output logic                           out_req,
    input  logic                           out_ack,
    output logic signed [SAMPLE_WIDTH-1:0] y_re,
    output logic signed [SAMPLE_WIDTH-1:0] y_im,
    output logic signed [SAMPLE_WIDTH-1:0] z_re,
    output logic signed [SAMPLE_WIDTH-1:0] z_im
);

    logic [ENG_STATE_WIDTH-1:0] state;
    logic                       accept;

    logic signed [SAMPLE_WIDTH-1:0] a_reg;
    logic signed [SAMPLE_WIDTH-1:0] b_reg;
    twiddle_word_t                  w_reg;
    logic signed [SAMPLE_WIDTH-1:0] t_re;

    // Shared multiplier
    logic signed [SAMPLE_WIDTH-1:0]  mult_w;
    logic signed [PRODUCT_WIDTH-1:0] product;
    logic signed [SAMPLE_WIDTH-1:0]  product_trunc;

    // Shared adder/subtractor
    logic signed [SAMPLE_WIDTH-1:0] alu_x;
    logic signed [SAMPLE_WIDTH-1:0] alu_y;
    logic                           alu_sub;
    logic signed [SAMPLE_WIDTH-1:0] alu_result;

    assign accept = (state == ENG_IDLE) && link.req && !link.ack;

    assign mult_w        = (state == ENG_MUL_RE) ? w_reg.parts.re : w_reg.parts.im;
    assign product       = b_reg * mult_w;
    assign product_trunc = product[FRAC_BITS+SAMPLE_WIDTH-1:FRAC_BITS];   // Bits 14 to 7

    // The adder is busy in every compute cycle:
    // a + t_re, then 0 - t_im, then a - t_re
    always_comb begin
        case (state)
            ENG_MUL_RE: begin
                alu_x   = a_reg;
                alu_y   = product_trunc;                  // t_re straight off the multiplier
                alu_sub = 1'b0;
            end
            ENG_MUL_IM: begin
                alu_x   = '0;
                alu_y   = product_trunc;                  // Negate t_im
                alu_sub = 1'b1;
            end
            default: begin
                alu_x   = a_reg;
                alu_y   = t_re;
                alu_sub = 1'b1;
            end
        endcase
    end

    assign alu_result = alu_sub ? alu_x - alu_y : alu_x + alu_y;   // Wraps to 8 bits

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= ENG_IDLE;
            link.ack <= 1'b0;
            out_req  <= 1'b0;
        end else begin
            if (accept)
                link.ack <= 1'b1;
            else if (!link.req)
                link.ack <= 1'b0;

            case (state)
                ENG_IDLE: begin
                    if (accept)
                        state <= ENG_MUL_RE;
                end
                ENG_MUL_RE:  state <= ENG_MUL_IM;
                ENG_MUL_IM:  state <= ENG_ADD_SUB;
                ENG_ADD_SUB: begin
                    out_req <= 1'b1;                      // Third cycle after the latch
                    state   <= ENG_OUTPUT;
                end
                ENG_OUTPUT: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= ENG_DRAIN;
                    end
                end
                ENG_DRAIN: begin
                    // Wait for the receiver to close the transfer
                    if (!out_ack)
                        state <= ENG_IDLE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            a_reg <= link.a;
            b_reg <= link.b;
            w_reg <= link.twiddle;
        end

        case (state)
            ENG_MUL_RE: begin
                t_re <= product_trunc;
                y_re <= alu_result;
            end
            ENG_MUL_IM: begin
                y_im <= product_trunc;
                z_im <= alu_result;
            end
            ENG_ADD_SUB: z_re <= alu_result;
            default: ;                                    // Results held for out_req
        endcase
    end

endmodule

`default_nettype wire

// ==== common/butterfly_pkg.sv ====
`default_nettype none

package butterfly_pkg;

    // Q1.7 sample and product widths
    localparam int SAMPLE_WIDTH  = 8;
    localparam int PRODUCT_WIDTH = 16;
    localparam int FRAC_BITS     = 7;                 // Truncation shift

    localparam int TWIDDLE_COUNT = 8;
    localparam int INDEX_WIDTH   = 3;

    localparam int FIFO_DEPTH       = 4;
    localparam int FIFO_PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // operand_capture FSM
    localparam int CAP_STATE_WIDTH = 2;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_IDLE    = 2'd0;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_OFFER   = 2'd1;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_ACK     = 2'd2;
    localparam logic [CAP_STATE_WIDTH-1:0] CAP_RELEASE = 2'd3;

    // butterfly_engine sequencer
    localparam int ENG_STATE_WIDTH = 3;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_IDLE    = 3'd0;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_MUL_RE  = 3'd1;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_MUL_IM  = 3'd2;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_ADD_SUB = 3'd3;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_OUTPUT  = 3'd4;
    localparam logic [ENG_STATE_WIDTH-1:0] ENG_DRAIN   = 3'd5;

    // One table word, real part in the upper byte
    typedef union packed {
        logic [2*SAMPLE_WIDTH-1:0] raw;
        struct packed {
            logic signed [SAMPLE_WIDTH-1:0] re;
            logic signed [SAMPLE_WIDTH-1:0] im;
        } parts;
    } twiddle_word_t;

    // W^k = exp(-j*2*pi*k/8) in Q1.7
    localparam twiddle_word_t TWIDDLE_TABLE [TWIDDLE_COUNT] = '{
        16'h7F00,                                     // W^0 = 1
        16'h5BA5,                                     // W^1 = 0.707 - 0.707j
        16'h0080,                                     // W^2 = -j
        16'hA5A5,                                     // W^3 = -0.707 - 0.707j
        16'h8000,                                     // W^4 = -1
        16'hA55B,                                     // W^5 = -0.707 + 0.707j
        16'h007F,                                     // W^6 = j
        16'h5B5B                                      // W^7 = 0.707 + 0.707j
    };

endpackage

`default_nettype wire

// ==== common/operand_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One operand set moving over a four-phase req/ack link
interface operand_if import butterfly_pkg::*; ();

    logic                           req;
    logic                           ack;
    logic signed [SAMPLE_WIDTH-1:0] a;
    logic signed [SAMPLE_WIDTH-1:0] b;
    twiddle_word_t                  twiddle;

    modport sender (
        output req,
        output a,
        output b,
        output twiddle,
        input  ack
    );

    modport receiver (
        input  req,
        input  a,
        input  b,
        input  twiddle,
        output ack
    );

endinterface

`default_nettype wire

// ==== radix2_butterfly.f ====
common/butterfly_pkg.sv
common/operand_if.sv
source/operand_capture.sv
source/operand_fifo.sv
butterfly/butterfly_engine.sv
source/radix2_butterfly.sv
testbench/radix2_butterfly_props.sv
testbench/radix2_butterfly_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the radix-2 butterfly testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module radix2_butterfly_tb \
    -Mdir obj_dir -o radix2_butterfly_sim \
    -f radix2_butterfly.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/radix2_butterfly_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Simulation did not report a pass, see $LOG"
exit 1

// ==== source/operand_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_capture import butterfly_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_req,
    output logic                           in_ack,
    input  logic signed [SAMPLE_WIDTH-1:0] a,
    input  logic signed [SAMPLE_WIDTH-1:0] b,
    input  logic [INDEX_WIDTH-1:0]         k,
    operand_if.sender                      link
);

    logic [CAP_STATE_WIDTH-1:0] state;
    logic                       load;

    assign load = (state == CAP_IDLE) && in_req;      // Take the set once per transfer

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= CAP_IDLE;
            in_ack   <= 1'b0;
            link.req <= 1'b0;
        end else begin
            case (state)
                CAP_IDLE: begin
                    if (in_req)
                        state <= CAP_OFFER;
                end
                CAP_OFFER: begin
                    if (!link.ack) begin              // Previous transfer fully closed
                        link.req <= 1'b1;
                        state    <= CAP_ACK;
                    end
                end
                CAP_ACK: begin
                    // Stalls here while the FIFO is full
                    if (link.ack) begin
                        link.req <= 1'b0;
                        in_ack   <= 1'b1;
                        state    <= CAP_RELEASE;
                    end
                end
                CAP_RELEASE: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Twiddle is looked up here so the engine only sees ready parts
    always_ff @(posedge clock) begin
        if (load) begin
            link.a       <= a;
            link.b       <= b;
            link.twiddle <= TWIDDLE_TABLE[k];
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_fifo import butterfly_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    operand_if.receiver push_link,
    operand_if.sender   pop_link
);

    logic signed [SAMPLE_WIDTH-1:0] mem_a  [FIFO_DEPTH];
    logic signed [SAMPLE_WIDTH-1:0] mem_b  [FIFO_DEPTH];
    twiddle_word_t                  mem_tw [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;
    logic                        full;
    logic                        push;
    logic                        pop;

    function automatic logic [FIFO_PTR_WIDTH-1:0] next_ptr(
        input logic [FIFO_PTR_WIDTH-1:0] ptr
    );
        if (ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
    assign push = push_link.req && !push_link.ack && !full;   // Full holds ack low
    assign pop  = pop_link.req && pop_link.ack;

    // Head entry is presented directly
    assign pop_link.a       = mem_a[rd_ptr];
    assign pop_link.b       = mem_b[rd_ptr];
    assign pop_link.twiddle = mem_tw[rd_ptr];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            push_link.ack <= 1'b0;
            pop_link.req  <= 1'b0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
        end else begin
            // Write side handshake
            if (push)
                push_link.ack <= 1'b1;
            else if (!push_link.req)
                push_link.ack <= 1'b0;

            if (push)
                wr_ptr <= next_ptr(wr_ptr);

            // Read side handshake, runs on its own
            if (pop) begin
                pop_link.req <= 1'b0;
                rd_ptr       <= next_ptr(rd_ptr);
            end else if (count != '0 && !pop_link.req && !pop_link.ack) begin
                pop_link.req <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem_a[wr_ptr]  <= push_link.a;
            mem_b[wr_ptr]  <= push_link.b;
            mem_tw[wr_ptr] <= push_link.twiddle;
        end
    end

endmodule

`default_nettype wire

// ==== source/radix2_butterfly.sv ====
`timescale 1ns/1ns
`default_nettype none

module radix2_butterfly import butterfly_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_req,
    output logic                           in_ack,
    input  logic signed [SAMPLE_WIDTH-1:0] a,
    input  logic signed [SAMPLE_WIDTH-1:0] b,
    input  logic [INDEX_WIDTH-1:0]         k,
    output logic                           out_req,
    input  logic                           out_ack,
    output logic signed [SAMPLE_WIDTH-1:0] y_re,
    output logic signed [SAMPLE_WIDTH-1:0] y_im,
    output logic signed [SAMPLE_WIDTH-1:0] z_re,
    output logic signed [SAMPLE_WIDTH-1:0] z_im
);

    operand_if cap_link ();                           // Capture to FIFO
    operand_if eng_link ();                           // FIFO to engine

    operand_capture u_capture (
        .clock  (clock),
        .reset  (reset),
        .in_req (in_req),
        .in_ack (in_ack),
        .a      (a),
        .b      (b),
        .k      (k),
        .link   (cap_link.sender)
    );

    operand_fifo u_fifo (
        .clock     (clock),
        .reset     (reset),
        .push_link (cap_link.receiver),
        .pop_link  (eng_link.sender)
    );

    butterfly_engine u_engine (
        .clock   (clock),
        .reset   (reset),
        .link    (eng_link.receiver),
        .out_req (out_req),
        .out_ack (out_ack),
        .y_re    (y_re),
        .y_im    (y_im),
        .z_re    (z_re),
        .z_im    (z_im)
    );

endmodule

`default_nettype wire

// ==== testbench/butterfly_vectors.txt ====
// Columns, hex: a b k pause y_re y_im z_re z_im
// pause 1 holds out_ack low for 20 cycles on that result
0A 40 00 00 49 00 CB 00
EC 64 01 00 33 B8 A5 48
05 CE 02 00 05 32 05 CE
9C BA 03 01 CD 31 6B CF
1E 80 04 00 9E 00 9E 00
C0 5A 05 00 80 3F 00 C1
7F 21 06 00 7F 20 7F E0
7F 50 07 00 B7 38 47 C8
7F 7F 00 00 FD 00 01 00
80 FF 01 00 7F 00 81 00
FF 80 02 01 FF 80 FF 80
2D 80 03 00 88 5B D2 A5
A6 64 04 00 42 00 0A 00
0C B3 05 00 42 C9 D6 37
FD 80 06 00 FD 81 FD 7F
80 80 07 00 25 A5 DB 5B
64 DB 00 00 3F 00 89 00
CE 39 03 00 A5 D7 F7 29

// ==== testbench/radix2_butterfly_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module radix2_butterfly_props import butterfly_pkg::*; (
    input logic                           clock,
    input logic                           reset,
    input logic                           in_req,
    input logic                           in_ack,
    input logic                           out_req,
    input logic                           out_ack,
    input logic signed [SAMPLE_WIDTH-1:0] y_re,
    input logic signed [SAMPLE_WIDTH-1:0] y_im,
    input logic signed [SAMPLE_WIDTH-1:0] z_re,
    input logic signed [SAMPLE_WIDTH-1:0] z_im
);

    int unsigned violation_count = 0;                  // Read by the testbench at the end

    out_req_held: assert property (@(posedge clock) disable iff (!reset)
        (out_req && !out_ack) |=> out_req
    ) else begin
        $error("out_req fell before out_ack was high");
        violation_count++;
    end

    results_stable: assert property (@(posedge clock) disable iff (!reset)
        out_req |=> (!out_req || $stable({y_re, y_im, z_re, z_im}))
    ) else begin
        $error("Results changed while out_req was high");
        violation_count++;
    end

    in_ack_on_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(in_ack) |-> $past(in_req)
    ) else begin
        $error("in_ack rose without in_req high");
        violation_count++;
    end

endmodule

`default_nettype wire

// ==== testbench/radix2_butterfly_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module radix2_butterfly_tb import butterfly_pkg::*; ();

    localparam int VECTOR_COUNT = 18;
    localparam int FIELD_COUNT  = 8;                   // a, b, k, pause, y_re, y_im, z_re, z_im
    localparam int PAUSE_CYCLES = 20;
    localparam int CYCLE_LIMIT  = 40 * VECTOR_COUNT + 100;

    logic                           clock;
    logic                           reset;
    logic                           in_req;
    logic                           in_ack;
    logic signed [SAMPLE_WIDTH-1:0] a;
    logic signed [SAMPLE_WIDTH-1:0] b;
    logic [INDEX_WIDTH-1:0]         k;
    logic                           out_req;
    logic                           out_ack;
    logic signed [SAMPLE_WIDTH-1:0] y_re;
    logic signed [SAMPLE_WIDTH-1:0] y_im;
    logic signed [SAMPLE_WIDTH-1:0] z_re;
    logic signed [SAMPLE_WIDTH-1:0] z_im;

    logic [7:0] vector_mem [VECTOR_COUNT*FIELD_COUNT];

    int          value_errors;
    int          protocol_errors;
    int          property_errors;
    int          accepted_count;                       // Sets acknowledged on the input side
    int          received_count;                       // Results acknowledged on the output side
    int          cycle_count;
    logic [31:0] rng_state;

    radix2_butterfly DUT (
        .clock   (clock),
        .reset   (reset),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .a       (a),
        .b       (b),
        .k       (k),
        .out_req (out_req),
        .out_ack (out_ack),
        .y_re    (y_re),
        .y_im    (y_im),
        .z_re    (z_re),
        .z_im    (z_im)
    );

    bind radix2_butterfly radix2_butterfly_props props (
        .clock   (clock),
        .reset   (reset),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_ack (out_ack),
        .y_re    (y_re),
        .y_im    (y_im),
        .z_re    (z_re),
        .z_im    (z_im)
    );

    always #50 clock = ~clock;                         // 100 ns period

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic compare_result(input string name, input logic signed [7:0] expected,
                                  input logic signed [7:0] actual, input int index);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected %0d, actual %0d (vector %0d)",
                     $time, name, expected, actual, index);
            value_errors++;
        end
    endtask

    task automatic check_idle();
        assert (!in_ack && !out_req) else begin
            $display("Handshake outputs not idle at %0t ns before the first request", $time);
            protocol_errors++;
        end
    endtask

    task automatic drive_inputs();
        int base;
        for (int i = 0; i < VECTOR_COUNT; i++) begin
            base = i * FIELD_COUNT;
            @(negedge clock);
            a      = vector_mem[base];
            b      = vector_mem[base+1];
            k      = vector_mem[base+2][INDEX_WIDTH-1:0];
            in_req = 1'b1;
            @(negedge clock);
            while (!in_ack) @(negedge clock);          // Stalls here under back-pressure
            in_req = 1'b0;
            accepted_count++;
            assert (accepted_count - received_count <= FIFO_DEPTH + 1) else begin
                $display("More than %0d sets were accepted ahead of their results at %0t ns",
                         FIFO_DEPTH + 1, $time);
                protocol_errors++;
            end
            while (in_ack) @(negedge clock);
        end
    endtask

    task automatic answer_outputs();
        int base;
        int delay;
        for (int i = 0; i < VECTOR_COUNT; i++) begin
            base = i * FIELD_COUNT;
            @(negedge clock);
            while (!out_req) @(negedge clock);
            compare_result("y_re", vector_mem[base+4], y_re, i);
            compare_result("y_im", vector_mem[base+5], y_im, i);
            compare_result("z_re", vector_mem[base+6], z_re, i);
            compare_result("z_im", vector_mem[base+7], z_im, i);
            if (vector_mem[base+3] != 8'h00) begin
                delay = PAUSE_CYCLES;                  // Input side keeps filling the FIFO
            end else begin
                rng_state = next_random(rng_state);
                delay     = int'(rng_state[2:0]);
            end
            repeat (delay) @(negedge clock);
            out_ack = 1'b1;
            received_count++;
            @(negedge clock);
            while (out_req) @(negedge clock);
            out_ack = 1'b0;
        end
    endtask

    initial begin
        clock           = 1'b0;
        reset           = 1'b0;
        in_req          = 1'b0;
        a               = '0;
        b               = '0;
        k               = '0;
        out_ack         = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        accepted_count  = 0;
        received_count  = 0;
        rng_state       = 32'ha96a_6965;
        $readmemh("testbench/butterfly_vectors.txt", vector_mem);

        @(negedge clock);
        repeat (4) begin
            @(negedge clock);
            check_idle();
        end
        reset = 1'b1;
        repeat (2) begin
            @(negedge clock);
            check_idle();
        end

        assert (!$isunknown(vector_mem[VECTOR_COUNT*FIELD_COUNT-1])) else begin
            $display("Vector file testbench/butterfly_vectors.txt is missing or too short");
            protocol_errors++;
        end

        if (protocol_errors == 0) begin
            fork
                drive_inputs();
                answer_outputs();
            join
            repeat (10) begin
                @(negedge clock);
                assert (!out_req) else begin
                    $display("Result offered at %0t ns after all vectors were answered", $time);
                    protocol_errors++;
                end
            end
        end

        property_errors = int'(DUT.props.violation_count);
        $display("Errors: %0d value, %0d protocol, %0d property", value_errors,
                 protocol_errors, property_errors);
        if (value_errors == 0 && protocol_errors == 0 && property_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d results still missing",
                 cycle_count, VECTOR_COUNT - received_count, VECTOR_COUNT);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
